// ==== list.f ====
+incdir+logic
logic/fpu_pkg.sv
logic/fp_pipe_stage.sv
logic/fp_op_decode.sv
logic/fp_noncomp_exec.sv
logic/fp_status_result.sv
logic/fp_wrapper.sv
sim/tb_fp_wrapper.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the FP32 slice testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_fp_wrapper -Mdir obj_dir

out=$(./obj_dir/Vtb_fp_wrapper 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^RESULT: PASS$"; then
  exit 0
fi
exit 1

// ==== sim/tb_fp_wrapper.sv ====
// FP32 coprocessor slice testbench
`timescale 1ns/1ns
`include "fpu_config.svh"

module tb_fp_wrapper;

  import fpu_pkg::*;

  localparam int N_REQ       = 400;
  localparam int TIMEOUT_CYC = 10 + 2 * N_REQ + 50;

  // Zeros, infinities, NaNs, subnormals, ones
  localparam logic [31:0] SPECIALS [12] = '{
    32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, 32'hff80_0000,
    32'h7fc0_0000, 32'hffc0_0000, 32'h7f80_0001, 32'hffa0_0000,
    32'h0000_0001, 32'h807f_ffff, 32'h3f80_0000, 32'hbf80_0000
  };

  // Expected response plus the cycle that carried the request
  typedef struct packed {
    logic [31:0] data;
    fp_status_t  flags;
    logic [31:0] acc;
  } exp_t;

  logic                                       clk_i;
  logic                                       rst_n_i;
  logic                                       apu_req_i;
  logic                                       apu_gnt_o;
  logic [`FPU_NARGS-1:0][`FPU_DATA_WIDTH-1:0] apu_operands_i;
  logic [`FPU_OP_WIDTH-1:0]                   apu_op_i;
  logic [`FPU_FLAG_WIDTH-1:0]                 apu_flags_i;
  logic                                       apu_rvalid_o;
  logic [`FPU_DATA_WIDTH-1:0]                 apu_rdata_o;
  fp_status_t                                 apu_rflags_o;

  integer      seed = 32'hb2a6;
  int unsigned cyc  = 0;   // Edges since time zero
  int          n_acc = 0;
  int          n_resp = 0;
  exp_t        exp_q [$];  // In-flight requests, oldest first

  fp_wrapper i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic stop_with_fail();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Half special values, half raw random bits
  function automatic logic [31:0] pick_operand();
    if (rand_below(2) == 0) return SPECIALS[rand_below(12)];
    return $random(seed);
  endfunction

  // Monotonic key, -0 lands just below +0
  function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : {1'b1, x[30:0]};
  endfunction

  // ----------------------------------------
  // Reference model, returns {result, flags}
  // ----------------------------------------
  function automatic logic [36:0] fp_ref(input logic [31:0] a, input logic [31:0] b,
                                         input logic [5:0] op_w, input logic [10:0] fl_w);
    fp_op_e      opc;
    logic [2:0]  rm;
    logic        legal;
    logic        a_nan;
    logic        b_nan;
    logic        any_snan;
    logic        both_zero;
    logic        tot_lt;
    logic        ieee_eq;
    logic        nv;
    logic [31:0] res;
    int          cls;
    opc = fp_op_e'(op_w[3:0]);
    rm  = fl_w[2:0];
    case (opc)
      SGNJ, CMP: legal = (rm <= 3'd2);
      MINMAX:    legal = (rm <= 3'd1);
      CLASSIFY:  legal = 1'b1;
      default:   legal = 1'b0;
    endcase
    legal     = legal && (op_w[5:4] == 2'b00) && (fl_w[8:3] == 6'd0);  // FP32 only
    a_nan     = (&a[30:23]) && (|a[22:0]);
    b_nan     = (&b[30:23]) && (|b[22:0]);
    any_snan  = (a_nan && !a[22]) || (b_nan && !b[22]);
    both_zero = (a[30:0] == 31'd0) && (b[30:0] == 31'd0);
    tot_lt    = order_key(a) < order_key(b);
    ieee_eq   = (a == b) || both_zero;
    res       = '0;
    nv        = 1'b0;
    if (!legal) begin
      nv = 1'b1;  // Zero result, invalid only
    end else begin
      case (opc)
        SGNJ: res = {(rm == 3'd0) ? b[31] : (rm == 3'd1) ? !b[31] : a[31] ^ b[31], a[30:0]};
        MINMAX: begin
          nv = any_snan;
          if (a_nan && b_nan) res = 32'h7fc0_0000;
          else if (a_nan)     res = b;
          else if (b_nan)     res = a;
          else                res = ((rm == 3'd1) == tot_lt) ? b : a;
        end
        CMP: begin
          nv = (rm == 3'd2) ? any_snan : (a_nan || b_nan);
          if (!a_nan && !b_nan) begin
            case (rm)
              3'd0:    res[0] = (tot_lt && !both_zero) || ieee_eq;
              3'd1:    res[0] = tot_lt && !both_zero;
              default: res[0] = ieee_eq;
            endcase
          end
        end
        default: begin
          if (a_nan)                   cls = a[22] ? 9 : 8;
          else if (&a[30:23])          cls = a[31] ? 0 : 7;
          else if (a[30:0] == 31'd0)   cls = a[31] ? 3 : 4;
          else if (a[30:23] == 8'd0)   cls = a[31] ? 2 : 5;
          else                         cls = a[31] ? 1 : 6;
          res = 32'd1 << cls;
        end
      endcase
    end
    return {res, nv, 4'b0000};
  endfunction

  // Legal ops mostly, plus each illegal flavour
  task automatic make_request(output logic [31:0] a, output logic [31:0] b,
                              output logic [5:0] op_w, output logic [10:0] fl_w);
    int         kind;
    logic [3:0] opc;
    logic [2:0] rm;
    logic [2:0] src_f;
    logic [2:0] dst_f;
    logic [1:0] vm;
    a     = pick_operand();
    b     = (rand_below(8) == 0) ? a : pick_operand();  // Equal pair now and then
    kind  = rand_below(10);
    if (kind inside {[2:5]} && rand_below(8) == 0) begin  // Opposite-signed zeros
      a = {a[31], 31'd0};
      b = {!a[31], 31'd0};
    end
    vm    = 2'b00;
    src_f = 3'd0;
    dst_f = 3'd0;
    opc   = CLASSIFY;
    rm    = 3'(rand_below(8));
    case (kind)
      0, 1: begin opc = SGNJ;   rm = 3'(rand_below(3)); end
      2, 3: begin opc = MINMAX; rm = 3'(rand_below(2)); end
      4, 5: begin opc = CMP;    rm = 3'(rand_below(3)); end
      6, 7: opc = CLASSIFY;
      8: begin
        opc = 4'(6 + rand_below(4));
        rm  = 3'd0;
        case (rand_below(4))
          0:       opc = (rand_below(2) == 0) ? 4'(rand_below(6)) : 4'(10 + rand_below(6));
          1:       if (rand_below(2) == 0) src_f = 3'(1 + rand_below(7));
                   else dst_f = 3'(1 + rand_below(7));
          2:       vm = 2'(1 + rand_below(3));  // Vector or modifier
          default: begin
            opc = (rand_below(2) == 0) ? MINMAX : CMP;
            rm  = 3'(3 + rand_below(5));        // Undefined sub-op
          end
        endcase
      end
      default: ;
    endcase
    op_w = {vm, opc};
    fl_w = {2'b00, src_f, dst_f, rm};
    if (kind == 9) begin   // Raw words, mostly illegal
      op_w = 6'($random(seed));
      fl_w = 11'($random(seed));
    end
  endtask

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_data(input logic [`FPU_DATA_WIDTH-1:0] got,
                            input logic [`FPU_DATA_WIDTH-1:0] exp, input int idx);
    if (got !== exp) begin
      $display("Mismatch at %0t: response %0d data %h, expected %h", $time, idx, got, exp);
      stop_with_fail();
    end
  endtask

  task automatic check_flags(input fp_status_t got, input fp_status_t exp, input int idx);
    if (got !== exp) begin
      $display("Mismatch at %0t: response %0d flags %b, expected %b", $time, idx, got, exp);
      stop_with_fail();
    end
  endtask

  task automatic check_latency(input int unsigned got, input int unsigned exp, input int idx);
    if (got != exp) begin
      $display("Mismatch at %0t: response %0d in cycle %0d, expected cycle %0d",
               $time, idx, got, exp);
      stop_with_fail();
    end
  endtask

  // ----------------------------------------
  // Monitor, compare and timeout
  // ----------------------------------------
  always @(negedge clk_i) begin
    exp_t        e;
    logic [36:0] r;
    if (rst_n_i && apu_req_i && apu_gnt_o) begin  // Taken on the next edge
      r       = fp_ref(apu_operands_i[0], apu_operands_i[1], apu_op_i, apu_flags_i);
      e.data  = r[36:5];
      e.flags = fp_status_t'(r[4:0]);
      e.acc   = cyc;  // Cycle with request and grant both high
      exp_q.push_back(e);
      n_acc++;
    end
  end

  always @(negedge clk_i) begin
    exp_t e;
    if (!rst_n_i && cyc > 0) begin
      if (apu_gnt_o !== 1'b0 || apu_rvalid_o !== 1'b0) begin
        $display("Grant or response valid was not low during reset at %0t", $time);
        stop_with_fail();
      end
    end else if (rst_n_i && apu_rvalid_o === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("Response at %0t arrived with no request outstanding", $time);
        stop_with_fail();
      end else begin
        e = exp_q.pop_front();
        check_data(apu_rdata_o, e.data, n_resp);
        check_flags(apu_rflags_o, e.flags, n_resp);
        check_latency(cyc, e.acc + `FPU_OTHERS_LAT + 2, n_resp);
        n_resp++;
      end
    end
  end

  always @(posedge clk_i) begin
    if (cyc >= TIMEOUT_CYC) begin
      $display("Timeout reached after %0d cycles, %0d responses missing", cyc, exp_q.size());
      stop_with_fail();
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [5:0]  op_w;
    logic [10:0] fl_w;
    rst_n_i        = 1'b0;
    apu_req_i      = 1'b0;
    apu_operands_i = '0;
    apu_op_i       = '0;
    apu_flags_i    = '0;
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    while (apu_gnt_o !== 1'b1) @(negedge clk_i);
    @(posedge clk_i);
    for (int i = 0; i < N_REQ; i++) begin
      make_request(a, b, op_w, fl_w);
      apu_req_i      <= 1'b1;
      apu_operands_i <= {b, a};    // Index 0 is a
      apu_op_i       <= op_w;
      apu_flags_i    <= fl_w;
      @(posedge clk_i);
      if (rand_below(4) == 0) begin  // Idle gap with junk payload
        apu_req_i      <= 1'b0;
        apu_operands_i <= {$random(seed), $random(seed)};
        @(posedge clk_i);
      end
    end
    apu_req_i <= 1'b0;
    while (exp_q.size() != 0) @(negedge clk_i);
    repeat (`FPU_OTHERS_LAT + 4) @(negedge clk_i);  // Window for stray pulses
    if (n_acc == N_REQ && n_resp == N_REQ && exp_q.size() == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("Run ended with %0d requests accepted and %0d answered", n_acc, n_resp);
      stop_with_fail();
    end
  end

endmodule

// ==== logic/fp_wrapper.sv ====
// FP32 coprocessor slice top
`timescale 1ns/1ns
`include "fpu_config.svh"

module fp_wrapper (
  // Clock and reset
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,

  // Request handshake
  input  logic                                       apu_req_i,
  output logic                                       apu_gnt_o,

  // Request payload
  input  logic [`FPU_NARGS-1:0][`FPU_DATA_WIDTH-1:0] apu_operands_i,
  input  logic [`FPU_OP_WIDTH-1:0]                   apu_op_i,
  input  logic [`FPU_FLAG_WIDTH-1:0]                 apu_flags_i,

  // Response, pulse only
  output logic                                       apu_rvalid_o,
  output logic [`FPU_DATA_WIDTH-1:0]                 apu_rdata_o,
  output fpu_pkg::fp_status_t                        apu_rflags_o
);

  import fpu_pkg::*;

  // ----------------------------------------
  // Stage links, OTHERS_LAT + 2 registers end to end
  // ----------------------------------------
  logic     dec_valid;
  fp_dec_t  dec;
  logic     exe_valid;
  fp_exec_t exe;

  fp_op_decode i_decode (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (apu_req_i),
    .operands_i  (apu_operands_i),
    .op_i        (apu_op_i),
    .flags_i     (apu_flags_i),
    .gnt_o       (apu_gnt_o),
    .dec_valid_o (dec_valid),
    .dec_o       (dec)
  );

  fp_noncomp_exec i_exec (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .dec_valid_i (dec_valid),
    .dec_i       (dec),
    .exe_valid_o (exe_valid),
    .exe_o       (exe)
  );

  fp_status_result i_result (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .exe_valid_i (exe_valid),
    .exe_i       (exe),
    .rvalid_o    (apu_rvalid_o),
    .rdata_o     (apu_rdata_o),
    .rflags_o    (apu_rflags_o)
  );

endmodule

// ==== logic/fp_status_result.sv ====
// APU response stage
`timescale 1ns/1ns
`include "fpu_config.svh"

module fp_status_result (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       exe_valid_i,
  input  fpu_pkg::fp_exec_t          exe_i,
  output logic                       rvalid_o,
  output logic [`FPU_DATA_WIDTH-1:0] rdata_o,
  output fpu_pkg::fp_status_t        rflags_o
);

  import fpu_pkg::*;

  // Illegal requests report invalid only
  localparam fp_status_t ILLEGAL_STATUS = '{nv: 1'b1, default: 1'b0};

  logic                       rvalid_q;
  logic [`FPU_DATA_WIDTH-1:0] rdata_q;
  fp_status_t                 rflags_q;

  // Response pulse, no back-pressure from the core
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) rvalid_q <= 1'b0;
    else          rvalid_q <= exe_valid_i;
  end

  // Result and flags, held between responses
  always_ff @(posedge clk_i) begin
    if (exe_valid_i) begin
      if (exe_i.illegal) begin
        rdata_q  <= '0;              // Zero result
        rflags_q <= ILLEGAL_STATUS;
      end else begin
        rdata_q  <= exe_i.result;
        rflags_q <= exe_i.status;
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign rflags_o = rflags_q;

  // Only NV can come out of the kept operation group
  a_only_nv: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_o |-> !(rflags_o.dz || rflags_o.of || rflags_o.uf || rflags_o.nx))
    else $error("unexpected DZ/OF/UF/NX in response");

  // A response never shows unknown data
  a_resp_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_o |-> !$isunknown({rdata_o, rflags_o}))
    else $error("response carries unknown bits");

endmodule

// ==== logic/fp_noncomp_exec.sv ====
// FP32 non-computational datapath
`timescale 1ns/1ns
`include "fpu_config.svh"

module fp_noncomp_exec (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              dec_valid_i,
  input  fpu_pkg::fp_dec_t  dec_i,
  output logic              exe_valid_o,
  output fpu_pkg::fp_exec_t exe_o
);

  import fpu_pkg::*;

  localparam logic [`FPU_DATA_WIDTH-1:0] CANON_NAN = 32'h7fc0_0000;

  // ----------------------------------------
  // Operand classification
  // ----------------------------------------
  logic [`FPU_NARGS-1:0][`FPU_DATA_WIDTH-1:0] opnd;
  logic [`FPU_NARGS-1:0] sgn;
  logic [`FPU_NARGS-1:0] is_zero;
  logic [`FPU_NARGS-1:0] is_sub;
  logic [`FPU_NARGS-1:0] is_norm;
  logic [`FPU_NARGS-1:0] is_inf;
  logic [`FPU_NARGS-1:0] is_nan;
  logic [`FPU_NARGS-1:0] is_qnan;
  logic [`FPU_NARGS-1:0] is_snan;

  assign opnd = {dec_i.op_b, dec_i.op_a};  // Index 0 is a

  for (genvar i = 0; i < `FPU_NARGS; i++) begin : g_class
    logic [7:0]  exp_f;
    logic [22:0] man_f;

    assign exp_f      = opnd[i][30:23];
    assign man_f      = opnd[i][22:0];
    assign sgn[i]     = opnd[i][31];
    assign is_zero[i] = (exp_f == 8'h00) && (man_f == '0);
    assign is_sub[i]  = (exp_f == 8'h00) && (man_f != '0);
    assign is_norm[i] = (exp_f != 8'h00) && (exp_f != 8'hff);
    assign is_inf[i]  = (exp_f == 8'hff) && (man_f == '0);
    assign is_nan[i]  = (exp_f == 8'hff) && (man_f != '0);
    assign is_qnan[i] = is_nan[i] && man_f[22];   // Quiet bit set
    assign is_snan[i] = is_nan[i] && !man_f[22];
  end

  // ----------------------------------------
  // Ordering of a against b
  // ----------------------------------------
  logic any_nan;
  logic any_snan;
  logic both_zero;
  logic mag_lt;     // |a| < |b|
  logic mag_eq;
  logic a_below_b;  // Total order, -0 below +0
  logic a_lt_b;     // IEEE less-than, zeros equal
  logic a_eq_b;

  assign any_nan   = |is_nan;
  assign any_snan  = |is_snan;
  assign both_zero = &is_zero;
  assign mag_lt    = opnd[0][30:0] < opnd[1][30:0];
  assign mag_eq    = opnd[0][30:0] == opnd[1][30:0];

  // Sign decides first, then magnitude flipped for negatives
  assign a_below_b = (sgn[0] != sgn[1]) ? sgn[0]
                   : (sgn[0] ? (!mag_lt && !mag_eq) : mag_lt);
  assign a_lt_b    = a_below_b && !both_zero;
  assign a_eq_b    = both_zero || (opnd[0] == opnd[1]);

  // RISC-V fclass mask of operand a, bit 0 is -inf
  logic [9:0] class_mask;

  assign class_mask = {is_qnan[0], is_snan[0],
                       !sgn[0] && is_inf[0],  !sgn[0] && is_norm[0],
                       !sgn[0] && is_sub[0],  !sgn[0] && is_zero[0],
                       sgn[0] && is_zero[0],  sgn[0] && is_sub[0],
                       sgn[0] && is_norm[0],  sgn[0] && is_inf[0]};

  // ----------------------------------------
  // Operation select
  // ----------------------------------------
  logic [`FPU_DATA_WIDTH-1:0] res;
  fp_status_t                 status;
  logic                       is_max;
  fp_exec_t                   exe_d;

  assign is_max = (dec_i.sub_op == RTZ);

  always_comb begin
    res    = '0;
    status = '0;
    case (dec_i.op)
      SGNJ: begin
        case (dec_i.sub_op)
          RTZ:     res = {!sgn[1], opnd[0][30:0]};         // Negated
          RDN:     res = {sgn[0] ^ sgn[1], opnd[0][30:0]};  // Xor
          default: res = {sgn[1], opnd[0][30:0]};
        endcase
      end
      MINMAX: begin
        status.nv = any_snan;
        if (&is_nan)                   res = CANON_NAN;
        else if (is_nan[0])            res = opnd[1];  // Other operand wins
        else if (is_nan[1])            res = opnd[0];
        else if (is_max != a_below_b)  res = opnd[0];
        else                           res = opnd[1];
      end
      CMP: begin
        case (dec_i.sub_op)
          RTZ: begin
            res[0]    = !any_nan && a_lt_b;
            status.nv = any_nan;   // Signaling compare
          end
          RDN: begin
            res[0]    = !any_nan && a_eq_b;
            status.nv = any_snan;  // Quiet compare
          end
          default: begin
            res[0]    = !any_nan && (a_lt_b || a_eq_b);
            status.nv = any_nan;
          end
        endcase
      end
      CLASSIFY: res = {22'b0, class_mask};
      default:  res = '0;  // Illegal, zeroed downstream anyway
    endcase
  end

  assign exe_d = '{result: res, status: status, illegal: dec_i.illegal};

  fp_pipe_stage #(
    .payload_t (fp_exec_t),
    .DEPTH     (`FPU_OTHERS_LAT)
  ) i_exe_pipe (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (dec_valid_i),
    .data_i  (exe_d),
    .valid_o (exe_valid_o),
    .data_o  (exe_o)
  );

endmodule

// ==== logic/fp_op_decode.sv ====
// APU request decode
`timescale 1ns/1ns
`include "fpu_config.svh"

module fp_op_decode (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  logic                                       req_i,
  input  logic [`FPU_NARGS-1:0][`FPU_DATA_WIDTH-1:0] operands_i,
  input  logic [`FPU_OP_WIDTH-1:0]                   op_i,
  input  logic [`FPU_FLAG_WIDTH-1:0]                 flags_i,
  output logic                                       gnt_o,
  output logic                                       dec_valid_o,
  output fpu_pkg::fp_dec_t                           dec_o
);

  import fpu_pkg::*;

  fp_op_e  op_code;
  logic    op_mod;    // Modifier bit, unsupported here
  logic    vec_op;    // Vector bit, unsupported here
  fp_fmt_e src_fmt;
  fp_fmt_e dst_fmt;
  fp_rm_e  sub_op;
  logic    sub_ok;    // Sub-op defined for this op
  logic    illegal;
  logic    gnt_q;
  logic    accept;
  fp_dec_t dec_d;

  // ----------------------------------------
  // Field split
  // ----------------------------------------
  assign op_code = fp_op_e'(op_i[`FPU_OPCODE_BITS-1:0]);
  assign op_mod  = op_i[`FPU_OPCODE_BITS];
  assign vec_op  = op_i[`FPU_OPCODE_BITS+1];

  // Integer format sits in the top bits and is ignored
  assign sub_op  = fp_rm_e'(flags_i[`FPU_RM_BITS-1:0]);
  assign dst_fmt = fp_fmt_e'(flags_i[`FPU_RM_BITS +: `FPU_FMT_BITS]);
  assign src_fmt = fp_fmt_e'(flags_i[`FPU_RM_BITS+`FPU_FMT_BITS +: `FPU_FMT_BITS]);

  // Legal op / sub-op pairs, anything else falls out as illegal
  always_comb begin
    case (op_code)
      SGNJ:     sub_ok = sub_op inside {RNE, RTZ, RDN};
      MINMAX:   sub_ok = sub_op inside {RNE, RTZ};
      CMP:      sub_ok = sub_op inside {RNE, RTZ, RDN};
      CLASSIFY: sub_ok = 1'b1;  // No sub-op
      default:  sub_ok = 1'b0;  // Dropped operations
    endcase
  end

  assign illegal = !sub_ok || op_mod || vec_op || (src_fmt != FP32) || (dst_fmt != FP32);

  // ----------------------------------------
  // Grant and decode register
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) gnt_q <= 1'b0;
    else          gnt_q <= 1'b1;  // Never stalls after reset
  end

  assign gnt_o  = gnt_q;
  assign accept = req_i && gnt_q;

  assign dec_d = '{op_a: operands_i[0], op_b: operands_i[1], op: op_code,
                   sub_op: sub_op, illegal: illegal};

  fp_pipe_stage #(
    .payload_t (fp_dec_t),
    .DEPTH     (1)
  ) i_dec_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (accept),
    .data_i  (dec_d),
    .valid_o (dec_valid_o),
    .data_o  (dec_o)
  );

  // Nothing enters the pipe unless granted the cycle before
  a_no_accept_wo_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dec_valid_o |-> $past(gnt_o)) else $error("request accepted while grant low");

endmodule

// ==== logic/fp_pipe_stage.sv ====
// Valid-qualified pipeline
`timescale 1ns/1ns

module fp_pipe_stage #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 1
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  logic [DEPTH-1:0] valid_q;         // One valid per stage
  payload_t         data_q [DEPTH];  // Payload, no reset

  // Valid chain, cleared by reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= valid_i;
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // Payload only moves with its valid
  always_ff @(posedge clk_i) begin
    if (valid_i) data_q[0] <= data_i;
    for (int i = 1; i < DEPTH; i++) begin
      if (valid_q[i-1]) data_q[i] <= data_q[i-1];
    end
  end

  assign valid_o = valid_q[DEPTH-1];
  assign data_o  = data_q[DEPTH-1];

  // Output valid must be clean once out of reset
  a_valid_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(valid_o)) else $error("pipe valid_o is unknown");

endmodule

// ==== logic/fpu_pkg.sv ====
// FPU shared types
`include "fpu_config.svh"

package fpu_pkg;

  // Operation codes, same order as the APU op field
  typedef enum logic [`FPU_OPCODE_BITS-1:0] {
    FMADD    = 4'd0,
    FNMSUB   = 4'd1,
    ADD      = 4'd2,
    MUL      = 4'd3,
    DIV      = 4'd4,
    SQRT     = 4'd5,
    SGNJ     = 4'd6,  // Kept
    MINMAX   = 4'd7,  // Kept
    CMP      = 4'd8,  // Kept
    CLASSIFY = 4'd9,  // Kept
    F2F      = 4'd10,
    F2I      = 4'd11,
    I2F      = 4'd12,
    CPKAB    = 4'd13,
    CPKCD    = 4'd14
  } fp_op_e;

  // Source and destination formats
  typedef enum logic [`FPU_FMT_BITS-1:0] {
    FP32    = 3'd0,
    FP64    = 3'd1,
    FP16    = 3'd2,
    FP8     = 3'd3,
    FP16ALT = 3'd4
  } fp_fmt_e;

  // Rounding modes, doubling as sub-op select
  typedef enum logic [`FPU_RM_BITS-1:0] {
    RNE = 3'd0,  // sgnj / min / le
    RTZ = 3'd1,  // sgnjn / max / lt
    RDN = 3'd2,  // sgnjx / eq
    RUP = 3'd3,
    RMM = 3'd4
  } fp_rm_e;

  // IEEE exception flags, RISC-V fflags order
  typedef struct packed {
    logic nv;  // Invalid
    logic dz;  // Divide by zero
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } fp_status_t;

  // Decoded request into execute
  typedef struct packed {
    logic [`FPU_DATA_WIDTH-1:0] op_a;
    logic [`FPU_DATA_WIDTH-1:0] op_b;
    fp_op_e                     op;
    fp_rm_e                     sub_op;
    logic                       illegal;
  } fp_dec_t;

  // Execute output into the response stage
  typedef struct packed {
    logic [`FPU_DATA_WIDTH-1:0] result;
    fp_status_t                 status;
    logic                       illegal;
  } fp_exec_t;

endpackage

// ==== logic/fpu_config.svh ====
// FPU slice configuration
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// Register stages in the non-computational unit
`define FPU_OTHERS_LAT 2

// Operands per request
`define FPU_NARGS 2

// Op word is {vec, mod, op[3:0]}
`define FPU_OP_WIDTH 6

// Flag word is {int_fmt, src_fmt, dst_fmt, rnd_mode}
`define FPU_FLAG_WIDTH 11

// Field widths inside the op and flag words
`define FPU_OPCODE_BITS 4
`define FPU_FMT_BITS 3
`define FPU_RM_BITS 3

// Operand and result width, FP32 only
`define FPU_DATA_WIDTH 32

`endif
